/* Makefile */
SIM  = obj_dir/Vuart_echo_tb
SRCS = $(wildcard src/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module uart_echo_tb -f vlog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule : tb_clock

`default_nettype wire

/* dv/uart_echo_tb.sv */
`default_nettype none

module uart_echo_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import uart_pkg::*;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 4;
    localparam int FRAME_CLKS   = 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CLKS = 20 * FRAME_CLKS;

    logic       clk;
    logic       rstn;
    logic       rx;
    logic       tx_hold;
    logic       tx;
    logic       rx_valid;
    rx_result_t rx_result;
    logic       overflow;

    // Frames still owed by the DUT
    rx_result_t rx_exp_q[$];
    byte_t      echo_q[$];

    rx_result_t rx_head;
    logic       rx_head_ok;
    logic       rx_valid_q;
    logic       overflow_q;
    int         drops_expected;
    int         drops_seen;
    logic       echo_expected;
    string      test_name;

    tb_clock #(
        .PERIOD_NS(8)
    ) tb_clock_inst (
        .clk(clk)
    );

    uart_echo_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) uart_echo_top_inst (
        .clk      (clk),
        .rstn     (rstn),
        .rx       (rx),
        .tx_hold  (tx_hold),
        .tx       (tx),
        .rx_valid (rx_valid),
        .rx_result(rx_result),
        .overflow (overflow)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic value_err(input string name, input logic [15:0] exp, input logic [15:0] act);
        abort_run($sformatf("ERR %s %s: expected 0x%0h, actual 0x%0h",
                            test_name, name, exp, act));
    endtask

    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] bits;
        rx_result_t res;
        bits          = {stop_bit, data, 1'b0};
        res.data      = data;
        res.frame_err = ~stop_bit;
        rx_exp_q.push_back(res);
        // Only a good byte with room in the FIFO comes back
        if (stop_bit) begin
            if (!tx_hold || echo_q.size() < FIFO_DEPTH) begin
                echo_q.push_back(data);
                echo_expected = 1'b1;
            end else begin
                drops_expected++;
            end
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic idle_bits(input int n);
        @(posedge clk);
        rx <= 1'b1;
        repeat (n * CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_glitch(input int clks);
        @(posedge clk);
        rx <= 1'b0;
        repeat (clks) @(posedge clk);
        rx <= 1'b1;
    endtask

    task automatic wait_settled(input logic with_echo);
        int n;
        n = 0;
        while (rx_exp_q.size() != 0 || (with_echo && echo_q.size() != 0)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CLKS) begin
                abort_run($sformatf("Timeout in test %s: DUT did not finish its frames",
                                    test_name));
            end
        end
    endtask

    task automatic send_and_settle(input byte_t data);
        send_frame(data, 1'b1);
        wait_settled(1'b1);
    endtask

    // Bookkeeping moves one cycle after each strobe, away from the check edge
    initial begin : result_tracker
        rx_valid_q = 1'b0;
        overflow_q = 1'b0;
        drops_seen = 0;
        rx_head_ok = 1'b0;
        rx_head    = '0;
        forever begin
            @(negedge clk);
            if (rx_valid_q && rx_exp_q.size() != 0) begin
                rx_exp_q.delete(0);
            end
            if (overflow_q) begin
                drops_seen++;
            end
            rx_valid_q = rx_valid;
            overflow_q = overflow;
            rx_head_ok = (rx_exp_q.size() != 0);
            if (rx_head_ok) begin
                rx_head = rx_exp_q[0];
            end
        end
    end

    initial begin : serial_monitor
        byte_t got;
        logic  prev;
        int    idle;
        prev = 1'b1;
        idle = 0;
        got  = '0;
        forever begin
            @(negedge clk);
            if (rstn && prev && !tx) begin
                if (echo_q.size() == 0) begin
                    abort_run($sformatf("Unexpected frame on tx in test %s", test_name));
                end
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                start_low : assert (!tx)
                    else value_err("echo start bit", 16'd0, 16'(tx));
                for (int k = 0; k < 8; k++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    got[k] = tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                stop_high : assert (tx)
                    else value_err("echo stop bit", 16'd1, 16'(tx));
                echo_match : assert (got == echo_q[0])
                    else value_err("echo byte", 16'(echo_q[0]), 16'(got));
                echo_q.delete(0);
                prev = 1'b1;
                idle = 0;
            end else begin
                prev = tx;
                if (echo_q.size() != 0 && !tx_hold) begin
                    idle++;
                end else begin
                    idle = 0;
                end
                if (idle > TIMEOUT_CLKS) begin
                    abort_run($sformatf("Timeout in test %s: no echo frame on tx", test_name));
                end
            end
        end
    end

    rx_matches : assert property (
        @(posedge clk) disable iff (!rstn)
        rx_valid |-> (rx_head_ok && rx_result == rx_head)
    ) else begin
        if (!rx_head_ok) begin
            abort_run($sformatf("rx_valid in test %s with no frame sent", test_name));
        end else begin
            value_err("rx_result", 16'(rx_head), 16'(rx_result));
        end
    end

    overflow_expected : assert property (
        @(posedge clk) disable iff (!rstn)
        overflow |-> (drops_seen < drops_expected)
    ) else abort_run($sformatf("Overflow in test %s with free FIFO space", test_name));

    // Line stays idle before any echo and while held
    tx_idle_high : assert property (
        @(posedge clk) disable iff (!rstn)
        (!echo_expected || tx_hold) |-> tx
    ) else abort_run($sformatf("tx left idle in test %s", test_name));

    initial begin : stimulus
        int drops_before;
        rx             = 1'b1;
        tx_hold        = 1'b0;
        rstn           = 1'b0;
        drops_expected = 0;
        echo_expected  = 1'b0;
        test_name      = "reset";
        void'($urandom(38));
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        idle_bits(2);

        test_name = "single_byte";
        send_and_settle(8'h55);
        send_and_settle(8'h00);
        send_and_settle(8'hFF);
        send_and_settle(8'($urandom()));

        test_name = "framing_error";
        send_frame(8'h3C, 1'b0);
        // Line must rise again before the next start edge
        idle_bits(1);
        wait_settled(1'b1);
        send_and_settle(8'hA7);
        idle_bits(1);

        test_name = "flow_control";
        drops_before = drops_seen;
        @(posedge clk);
        tx_hold <= 1'b1;
        repeat (6) send_frame(8'($urandom()), 1'b1);
        wait_settled(1'b0);
        // Overflow of the last byte trails its rx_valid by one cycle
        repeat (2) @(negedge clk);
        overflow_count : assert (drops_seen - drops_before == 2)
            else value_err("overflow pulses", 16'd2, 16'(drops_seen - drops_before));
        @(posedge clk);
        tx_hold <= 1'b0;
        wait_settled(1'b1);
        idle_bits(1);

        test_name = "stream";
        repeat (20) send_frame(8'($urandom()), 1'b1);
        wait_settled(1'b1);
        idle_bits(1);

        test_name = "false_start";
        send_glitch(4);
        idle_bits(12);
        send_and_settle(8'h96);
        idle_bits(4);

        if (rx_exp_q.size() == 0 && echo_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("Frames still outstanding at the end of the run");
        end
    end

endmodule : uart_echo_tb

`default_nettype wire

/* src/uart_byte_fifo.sv */
`default_nettype none

module uart_byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            push,
    input  uart_pkg::byte_t wr_data,
    input  logic            pop,
    output uart_pkg::byte_t rd_data,
    output logic            empty,
    output logic            overflow
);

    import uart_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    // Extra MSB tells full from empty
    typedef logic [ADDR_W:0] ptr_t;

    byte_t mem [FIFO_DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    logic  full;
    logic  do_push;
    logic  do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign do_pop  = pop && !empty;
    // A pop in the same cycle frees the slot
    assign do_push = push && (!full || do_pop);

    assign rd_data = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            overflow <= push && !do_push;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    // Transmitter must only fetch a byte that is there
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rstn)
        pop |-> !empty
    );

endmodule : uart_byte_fifo

`default_nettype wire

/* src/uart_echo_top.sv */
`default_nettype none

module uart_echo_top #(
    parameter int CLKS_PER_BIT = 434,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rx,
    input  logic                 tx_hold,
    output logic                 tx,
    output logic                 rx_valid,
    output uart_pkg::rx_result_t rx_result,
    output logic                 overflow
);

    import uart_pkg::*;

    logic  fifo_push;
    logic  fifo_pop;
    logic  fifo_empty;
    byte_t fifo_rd_data;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_rx_inst (
        .clk      (clk),
        .rstn     (rstn),
        .rx       (rx),
        .rx_valid (rx_valid),
        .rx_result(rx_result)
    );

    // Bytes with a bad stop bit are reported but never echoed
    assign fifo_push = rx_valid && !rx_result.frame_err;

    uart_byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_byte_fifo_inst (
        .clk     (clk),
        .rstn    (rstn),
        .push    (fifo_push),
        .wr_data (rx_result.data),
        .pop     (fifo_pop),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty),
        .overflow(overflow)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) uart_tx_inst (
        .clk    (clk),
        .rstn   (rstn),
        .empty  (fifo_empty),
        .rd_data(fifo_rd_data),
        .tx_hold(tx_hold),
        .pop    (fifo_pop),
        .tx     (tx)
    );

endmodule : uart_echo_top

`default_nettype wire

/* src/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // One data byte of a serial frame
    typedef logic [7:0] byte_t;

    // What the receiver reports for each frame
    typedef struct packed {
        byte_t data;
        logic  frame_err;
    } rx_result_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage : uart_pkg

`default_nettype wire

/* src/uart_rx.sv */
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rx,
    output logic                 rx_valid,
    output uart_pkg::rx_result_t rx_result
);

    import uart_pkg::*;

    localparam int CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    typedef logic [CNT_W-1:0] bit_cnt_t;

    logic [2:0] rx_sync_q;
    logic       rx_s;
    logic       start_edge;
    rx_state_t  state;
    bit_cnt_t   bit_cnt;
    logic [2:0] bit_idx;
    byte_t      shift_q;
    logic       half_end;
    logic       bit_end;

    // Two sync flops, third stage only for edge detect
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_sync_q <= 3'b111;
        end else begin
            rx_sync_q <= {rx_sync_q[1:0], rx};
        end
    end

    assign rx_s       = rx_sync_q[1];
    assign start_edge = rx_sync_q[2] & ~rx_sync_q[1];

    assign half_end = (bit_cnt == bit_cnt_t'(HALF_BIT - 1));
    assign bit_end  = (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= RX_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        bit_cnt <= '0;
                        // Line back high at mid-bit means a glitch
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        bit_cnt  <= '0;
                        state    <= RX_IDLE;
                        rx_valid <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
        if (state == RX_STOP && bit_end) begin
            rx_result.data      <= shift_q;
            rx_result.frame_err <= ~rx_s;
        end
    end

    a_valid_single : assert property (
        @(posedge clk) disable iff (!rstn)
        rx_valid |=> !rx_valid
    );

    a_valid_after_stop : assert property (
        @(posedge clk) disable iff (!rstn)
        rx_valid |-> ($past(state) == RX_STOP && state == RX_IDLE)
    );

endmodule : uart_rx

`default_nettype wire

/* src/uart_tx.sv */
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            empty,
    input  uart_pkg::byte_t rd_data,
    input  logic            tx_hold,
    output logic            pop,
    output logic            tx
);

    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef logic [CNT_W-1:0] bit_cnt_t;

    tx_state_t  state;
    bit_cnt_t   bit_cnt;
    logic [2:0] bit_idx;
    byte_t      shift_q;
    logic       bit_end;
    logic       stop_end;
    logic       next_bit;

    // Hold only matters between frames
    assign pop = (state == TX_IDLE) && !empty && !tx_hold;

    assign bit_end = (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));
    // Last stop cycle is the IDLE cycle that may pop
    assign stop_end = (bit_cnt == bit_cnt_t'(CLKS_PER_BIT - 2));

    assign next_bit = bit_end &&
                      (state == TX_START || (state == TX_DATA && bit_idx != 3'd7));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    tx      <= 1'b1;
                    if (pop) begin
                        state <= TX_START;
                        tx    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        state   <= TX_DATA;
                        tx      <= shift_q[0];
                    end else begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= shift_q[0];
                        end
                    end else begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    end
                end
                TX_STOP: begin
                    if (stop_end) begin
                        bit_cnt <= '0;
                        state   <= TX_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= rd_data;
        end else if (next_bit) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_line_high : assert property (
        @(posedge clk) disable iff (!rstn)
        (state == TX_IDLE || state == TX_STOP) |-> tx
    );

    a_pop_starts_frame : assert property (
        @(posedge clk) disable iff (!rstn)
        pop |-> (state == TX_IDLE) ##1 (state == TX_START && !tx)
    );

endmodule : uart_tx

`default_nettype wire

/* vlog.f */
src/uart_pkg.sv
src/uart_rx.sv
src/uart_byte_fifo.sv
src/uart_tx.sv
src/uart_echo_top.sv
dv/tb_clock.sv
dv/uart_echo_tb.sv
